// File: Bender.yml
package:
  name: mci_subsys

sources:
  - rtl/cif_pkg.sv
  - rtl/mci_reg_pkg.sv
  - rtl/mci_mtime.sv
  - rtl/mci_reg.sv
  - rtl/mci_reg_top.sv
  - rtl/mci_subsys_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mci_subsys_tb.sv

// File: dv/mci_subsys_tb_tasks.svh
/*
 * Subsystem testbench tasks
 * Single-cycle fabric accesses, value checks, the byte-merge model
 * and the directed tests, included into the testbench module
 */

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

// Register value after a strobed write merged byte by byte
function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                            input logic [3:0] strb);
    logic [31:0] res;
    int          b;
    res = old;
    for (b = 0; b < 4; b++)
        if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    return res;
endfunction

// One request cycle from a falling edge with the response sampled mid-cycle
task automatic cif_access(input logic wr, input logic [CIF_ADDR_W-1:0] addr,
                          input logic [CIF_DATA_W-1:0] data, input logic [CIF_STRB_W-1:0] strb,
                          input logic exp_err, output logic [CIF_DATA_W-1:0] rdata);
    cif_dv    = 1'b1;
    cif_write = wr;
    cif_addr  = addr;
    cif_wdata = data;
    cif_wstrb = strb;
    #1;                                                 // Combinational response settled
    rdata = cif_rdata;
    check_val("cif_error", cif_error, exp_err);
    check_val("cif_hold", cif_hold, 1'b0);
    if (wr) check_val("cif_rdata", cif_rdata, '0);      // No data on a write
    @(negedge clk);
    cif_dv    = 1'b0;
    cif_write = 1'b0;
endtask

task automatic cif_write_word(input logic [CIF_ADDR_W-1:0] addr, input logic [CIF_DATA_W-1:0] data,
                              input logic [CIF_STRB_W-1:0] strb, input logic exp_err);
    logic [CIF_DATA_W-1:0] rd_unused;
    cif_access(1'b1, addr, data, strb, exp_err, rd_unused);
endtask

task automatic cif_read_word(input logic [CIF_ADDR_W-1:0] addr, input logic exp_err,
                             output logic [CIF_DATA_W-1:0] data);
    cif_access(1'b0, addr, '0, '0, exp_err, data);
endtask

task automatic read_check(input string name, input logic [CIF_ADDR_W-1:0] addr,
                          input logic [CIF_DATA_W-1:0] exp, input logic exp_err);
    logic [CIF_DATA_W-1:0] rd;
    cif_read_word(addr, exp_err, rd);
    check_val(name, rd, exp);
endtask

task automatic wait_timer_int(input logic level, input int max_cycles, input string what);
    int n;
    n = 0;
    while (timer_int !== level && n < max_cycles) begin
        @(negedge clk);
        n++;
    end
    if (timer_int !== level) begin
        errors++;
        $display("Timed out after %0d cycles waiting for timer_int to %s", max_cycles, what);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset_identity();
    check_val("error_fatal", error_fatal, 1'b0);
    check_val("timer_int", timer_int, 1'b0);
    check_val("generic_output_wires", generic_output_wires, '0);
    read_check("CAPABILITIES", ADDR_CAPABILITIES, CAPABILITIES_VAL, 1'b0);
    read_check("HW_REV_ID", ADDR_HW_REV_ID, HW_REV_ID_VAL, 1'b0);
endtask

task automatic test_byte_strobes();
    logic [CIF_DATA_W-1:0] data;
    logic [31:0]           r;
    int                    i;
    flow_model    = '0;
    scratch_model = '0;
    gen_model     = '0;
    for (i = 0; i < 6; i++) begin
        data = $random(seed);
        r    = (i == 0) ? 32'hFFF : $random(seed);      // Full strobes first, then mixed
        cif_write_word(ADDR_FLOW_STATUS, data, r[3:0], 1'b0);
        flow_model = merge_bytes(flow_model, data, r[3:0]);
        read_check("FLOW_STATUS", ADDR_FLOW_STATUS, flow_model, 1'b0);
        cif_write_word(ADDR_SCRATCH, ~data, r[7:4], 1'b0);
        scratch_model = merge_bytes(scratch_model, ~data, r[7:4]);
        read_check("SCRATCH", ADDR_SCRATCH, scratch_model, 1'b0);
        cif_write_word(ADDR_GENERIC_OUT, data ^ r, r[11:8], 1'b0);
        gen_model = merge_bytes(gen_model, data ^ r, r[11:8]);
        read_check("GENERIC_OUT", ADDR_GENERIC_OUT, gen_model, 1'b0);
        check_val("generic_output_wires", generic_output_wires, gen_model);
    end
endtask

task automatic test_access_errors();
    logic [GENERIC_W-1:0] gin;
    read_check("unmapped 0x34", 16'h0034, '0, 1'b1);
    read_check("unmapped 0x3C", 16'h003C, '0, 1'b1);
    read_check("unmapped 0x09", 16'h0009, '0, 1'b1);  // Off-word offset
    cif_write_word(ADDR_CAPABILITIES, 32'hFFFF_FFFF, 4'hF, 1'b1);
    cif_write_word(ADDR_HW_REV_ID, 32'hFFFF_FFFF, 4'hF, 1'b1);
    cif_write_word(ADDR_GENERIC_IN, 32'hFFFF_FFFF, 4'hF, 1'b1);
    cif_write_word(16'h0038, 32'hFFFF_FFFF, 4'hF, 1'b1);
    read_check("CAPABILITIES", ADDR_CAPABILITIES, CAPABILITIES_VAL, 1'b0);
    read_check("HW_REV_ID", ADDR_HW_REV_ID, HW_REV_ID_VAL, 1'b0);
    read_check("FLOW_STATUS", ADDR_FLOW_STATUS, flow_model, 1'b0);
    read_check("SCRATCH", ADDR_SCRATCH, scratch_model, 1'b0);
    read_check("GENERIC_OUT", ADDR_GENERIC_OUT, gen_model, 1'b0);
    check_val("generic_output_wires", generic_output_wires, gen_model);
    gin                 = $random(seed);
    generic_input_wires = gin;
    read_check("GENERIC_IN", ADDR_GENERIC_IN, gin, 1'b0);
endtask

task automatic test_scratch_lock();
    cif_write_word(ADDR_SCRATCH_LOCK, 32'h1, 4'hF, 1'b0);
    read_check("SCRATCH_LOCK", ADDR_SCRATCH_LOCK, 32'h1, 1'b0);
    cif_write_word(ADDR_SCRATCH, $random(seed), 4'hF, 1'b1);
    read_check("SCRATCH", ADDR_SCRATCH, scratch_model, 1'b0);
    cif_write_word(ADDR_SCRATCH_LOCK, 32'h0, 4'hF, 1'b0);      // Set-only bit
    read_check("SCRATCH_LOCK", ADDR_SCRATCH_LOCK, 32'h1, 1'b0);
endtask

task automatic test_fatal_errors();
    hw_error_fatal = 8'h08;                             // One-cycle pulse
    @(negedge clk);
    hw_error_fatal = '0;
    read_check("HW_ERROR_FATAL", ADDR_HW_ERROR_FATAL, 32'h08, 1'b0);
    check_val("error_fatal", error_fatal, 1'b1);
    cif_write_word(ADDR_HW_ERROR_FATAL, 32'h08, 4'h1, 1'b0);
    read_check("HW_ERROR_FATAL", ADDR_HW_ERROR_FATAL, 32'h0, 1'b0);
    check_val("error_fatal", error_fatal, 1'b0);
    hw_error_fatal = 8'h01;                             // Set and clear together
    cif_write_word(ADDR_HW_ERROR_FATAL, 32'h01, 4'h1, 1'b0);
    hw_error_fatal = '0;
    read_check("HW_ERROR_FATAL", ADDR_HW_ERROR_FATAL, 32'h01, 1'b0);
    cif_write_word(ADDR_HW_ERROR_FATAL, 32'h01, 4'h1, 1'b0);
    check_val("error_fatal", error_fatal, 1'b0);
    cif_write_word(ADDR_FW_ERROR_FATAL, 32'h0000_0100, 4'h2, 1'b0);
    check_val("error_fatal", error_fatal, 1'b1);
    read_check("FW_ERROR_FATAL", ADDR_FW_ERROR_FATAL, 32'h0000_0100, 1'b0);
    cif_write_word(ADDR_FW_ERROR_FATAL, 32'h0, 4'hF, 1'b0);
    check_val("error_fatal", error_fatal, 1'b0);
endtask

task automatic test_timer();
    logic [CIF_DATA_W-1:0] val, hi, lo;
    val = $random(seed) & 32'h7FFF_FFFF;                // Headroom so the low half never carries
    cif_write_word(ADDR_MTIME_L, val, 4'hF, 1'b0);
    read_check("MTIME_L", ADDR_MTIME_L, val, 1'b0);
    repeat (4) @(negedge clk);
    read_check("MTIME_L", ADDR_MTIME_L, val + 32'd5, 1'b0);    // Five cycles on
    cif_read_word(ADDR_MTIME_H, 1'b0, hi);
    cif_read_word(ADDR_MTIME_L, 1'b0, lo);
    cif_write_word(ADDR_MTIMECMP_L, lo + 32'd30, 4'hF, 1'b0);
    cif_write_word(ADDR_MTIMECMP_H, hi, 4'hF, 1'b0);
    check_val("timer_int", timer_int, 1'b0);            // Compare still ahead
    read_check("MTIMECMP_L", ADDR_MTIMECMP_L, lo + 32'd30, 1'b0);
    wait_timer_int(1'b1, 100, "rise");
    cif_write_word(ADDR_MTIMECMP_H, 32'hFFFF_FFFF, 4'hF, 1'b0);
    wait_timer_int(1'b0, 10, "fall");
endtask

// File: dv/mci_subsys_tb.sv
/*
 * Management controller subsystem testbench
 * Clock, reset and DUT instance, then the directed fabric tests
 * for the register map, fatal errors and the machine timer
 */

module mci_subsys_tb
    import cif_pkg::*;
    import mci_reg_pkg::*;
();

    logic                  clk, rst;
    logic                  cif_dv, cif_write;
    logic [CIF_ADDR_W-1:0] cif_addr;
    logic [CIF_DATA_W-1:0] cif_wdata, cif_rdata;
    logic [CIF_STRB_W-1:0] cif_wstrb;
    logic                  cif_error, cif_hold;
    logic [HW_ERR_W-1:0]   hw_error_fatal;
    logic [GENERIC_W-1:0]  generic_input_wires, generic_output_wires;
    logic                  error_fatal, timer_int;

    integer                seed;
    int                    errors, checks;
    logic [CIF_DATA_W-1:0] flow_model, scratch_model;   // Expected register contents
    logic [GENERIC_W-1:0]  gen_model;

    mci_subsys_top uut (
        .clk (clk), .rst (rst),
        .cif_dv (cif_dv), .cif_write (cif_write), .cif_addr (cif_addr),
        .cif_wdata (cif_wdata), .cif_wstrb (cif_wstrb), .cif_rdata (cif_rdata),
        .cif_error (cif_error), .cif_hold (cif_hold),
        .hw_error_fatal (hw_error_fatal), .generic_input_wires (generic_input_wires),
        .generic_output_wires (generic_output_wires), .error_fatal (error_fatal),
        .timer_int (timer_int)
    );

    `include "mci_subsys_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                          // Period 4
    end

    //////////////////////////////////////////////////////////////////////
    // Reset and test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed                = 32'h89eb_6651;
        errors              = 0;
        checks              = 0;
        rst                 = 1'b1;
        cif_dv              = 1'b0;
        cif_write           = 1'b0;
        cif_addr            = '0;
        cif_wdata           = '0;
        cif_wstrb           = '0;
        hw_error_fatal      = '0;
        generic_input_wires = '0;
        repeat (4) @(posedge clk);                      // Four cycles in reset
        @(negedge clk);
        rst = 1'b0;

        test_reset_identity();
        test_byte_strobes();
        test_access_errors();
        test_scratch_lock();                            // Locks SCRATCH for good
        test_fatal_errors();
        test_timer();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : mci_subsys_tb

// File: mci_subsys_top.f
+incdir+dv
rtl/cif_pkg.sv
rtl/mci_reg_pkg.sv
rtl/mci_mtime.sv
rtl/mci_reg.sv
rtl/mci_reg_top.sv
rtl/mci_subsys_top.sv
dv/mci_subsys_tb.sv

// File: rtl/cif_pkg.sv
/*
 * Fabric port package
 * Widths of the single-cycle request/response fabric port
 * shared by the register wrapper, the subsystem top and the testbench
 */

package cif_pkg;

    //////////////////////////////////////////////////////////////////////
    // Request/response widths
    //////////////////////////////////////////////////////////////////////

    localparam int CIF_ADDR_W = 16;                // Byte address
    localparam int CIF_DATA_W = 32;                // Read and write data
    localparam int CIF_STRB_W = CIF_DATA_W / 8;    // One strobe per byte

    // Upper address bits beyond the register window are don't-care
    // for the management register block

endpackage : cif_pkg

// File: rtl/mci_mtime.sv
/*
 * Machine timer
 * Free-running 64-bit counter and compare value, each loadable one
 * 32-bit half at a time. The timer interrupt is the registered
 * result of count >= compare.
 */

module mci_mtime
    import mci_reg_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mtime_l_we,
    input  logic                          mtime_h_we,
    input  logic                          mtimecmp_l_we,
    input  logic                          mtimecmp_h_we,
    input  logic [MCI_REG_DATA_WIDTH-1:0] mtime_wdata,  // Already byte-merged
    output logic [MTIME_W-1:0]            mtime,
    output logic [MTIME_W-1:0]            mtimecmp,
    output logic                          timer_int
);

    localparam int HW = MCI_REG_DATA_WIDTH;        // Half width

    // Counter, a load replaces the increment for that cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else if (mtime_l_we) begin
            mtime[HW-1:0] <= mtime_wdata;
        end else if (mtime_h_we) begin
            mtime[MTIME_W-1:HW] <= mtime_wdata;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '1;                        // Never fires out of reset
        end else begin
            if (mtimecmp_l_we) mtimecmp[HW-1:0]      <= mtime_wdata;
            if (mtimecmp_h_we) mtimecmp[MTIME_W-1:HW] <= mtime_wdata;
        end
    end

    // Unsigned compare, one cycle late
    always_ff @(posedge clk) begin
        if (rst) timer_int <= 1'b0;
        else     timer_int <= (mtime >= mtimecmp);
    end

endmodule : mci_mtime

// File: rtl/mci_reg.sv
/*
 * Management controller register file
 * Decodes single-cycle register accesses, holds the flow status,
 * fatal error, scratch and generic wire registers, muxes read data
 * and flags access errors. Timer writes leave as merged strobes.
 */

module mci_reg
    import mci_reg_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,

    // Register access port
    input  logic                              s_cpuif_req,
    input  logic                              s_cpuif_req_is_wr,
    input  logic [MCI_REG_MIN_ADDR_WIDTH-1:0] s_cpuif_addr,
    input  logic [MCI_REG_DATA_WIDTH-1:0]     s_cpuif_wr_data,
    input  logic [MCI_REG_DATA_WIDTH-1:0]     s_cpuif_wr_biten,
    output logic [MCI_REG_DATA_WIDTH-1:0]     s_cpuif_rd_data,
    output logic                              s_cpuif_rd_err,
    output logic                              s_cpuif_wr_err,

    // Hardware hooks
    input  logic [HW_ERR_W-1:0]               hw_error_fatal,
    input  logic [GENERIC_W-1:0]              generic_input_wires,
    output logic [GENERIC_W-1:0]              generic_output_wires,
    output logic                              error_fatal,

    // Timer access
    input  logic [MTIME_W-1:0]                mtime,
    input  logic [MTIME_W-1:0]                mtimecmp,
    output logic                              mtime_l_we,
    output logic                              mtime_h_we,
    output logic                              mtimecmp_l_we,
    output logic                              mtimecmp_h_we,
    output logic [MCI_REG_DATA_WIDTH-1:0]     mtime_wdata
);

    localparam int DW = MCI_REG_DATA_WIDTH;

    logic          rd_req, wr_req;
    logic          addr_valid;                     // Offset is mapped
    logic          ro_hit;                         // Offset has no writable state
    logic [DW-1:0] rd_mux;
    logic [DW-1:0] timer_cur;                      // Current value of addressed timer half

    // Storage
    logic [DW-1:0]       flow_status;
    logic [HW_ERR_W-1:0] hw_err_q;
    logic [HW_ERR_W-1:0] hw_err_clr;
    logic [DW-1:0]       fw_err_q;
    logic                scratch_lock;
    logic [DW-1:0]       scratch;

    // Merge enabled bits of the write data into a register value
    function automatic logic [DW-1:0] wr_merge(input logic [DW-1:0] cur,
                                               input logic [DW-1:0] data,
                                               input logic [DW-1:0] biten);
        return (cur & ~biten) | (data & biten);
    endfunction

    assign rd_req = s_cpuif_req & ~s_cpuif_req_is_wr;
    assign wr_req = s_cpuif_req &  s_cpuif_req_is_wr;

    //////////////////////////////////////////////////////////////////////
    // Decode and read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        addr_valid = 1'b1;
        rd_mux     = '0;
        case (s_cpuif_addr)
            ADDR_CAPABILITIES:   rd_mux = CAPABILITIES_VAL;
            ADDR_HW_REV_ID:      rd_mux = HW_REV_ID_VAL;
            ADDR_FLOW_STATUS:    rd_mux = flow_status;
            ADDR_HW_ERROR_FATAL: rd_mux = {{(DW-HW_ERR_W){1'b0}}, hw_err_q};
            ADDR_FW_ERROR_FATAL: rd_mux = fw_err_q;
            ADDR_MTIME_L:        rd_mux = mtime[DW-1:0];         // Live count
            ADDR_MTIME_H:        rd_mux = mtime[MTIME_W-1:DW];
            ADDR_MTIMECMP_L:     rd_mux = mtimecmp[DW-1:0];
            ADDR_MTIMECMP_H:     rd_mux = mtimecmp[MTIME_W-1:DW];
            ADDR_SCRATCH_LOCK:   rd_mux = {{(DW-1){1'b0}}, scratch_lock};
            ADDR_SCRATCH:        rd_mux = scratch;
            ADDR_GENERIC_OUT:    rd_mux = generic_output_wires;
            ADDR_GENERIC_IN:     rd_mux = generic_input_wires;
            default:             addr_valid = 1'b0;      // Unmapped, reads zero
        endcase
    end

    assign ro_hit = (s_cpuif_addr == ADDR_CAPABILITIES) |
                    (s_cpuif_addr == ADDR_HW_REV_ID)    |
                    (s_cpuif_addr == ADDR_GENERIC_IN);

    assign s_cpuif_rd_data = rd_req ? rd_mux : '0;  // Zero outside a valid read
    assign s_cpuif_rd_err  = rd_req & ~addr_valid;
    assign s_cpuif_wr_err  = wr_req & (~addr_valid | ro_hit |
                             ((s_cpuif_addr == ADDR_SCRATCH) & scratch_lock));

    //////////////////////////////////////////////////////////////////////
    // Storage registers
    //////////////////////////////////////////////////////////////////////

    // W1C mask, only enabled bytes can clear
    assign hw_err_clr = {HW_ERR_W{wr_req & (s_cpuif_addr == ADDR_HW_ERROR_FATAL)}} &
                        s_cpuif_wr_data[HW_ERR_W-1:0] & s_cpuif_wr_biten[HW_ERR_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            flow_status          <= '0;
            hw_err_q             <= '0;
            fw_err_q             <= '0;
            scratch_lock         <= 1'b0;
            scratch              <= '0;
            generic_output_wires <= '0;
        end else begin
            hw_err_q <= (hw_err_q & ~hw_err_clr) | hw_error_fatal;  // Set beats clear
            if (wr_req && s_cpuif_addr == ADDR_FLOW_STATUS)
                flow_status <= wr_merge(flow_status, s_cpuif_wr_data, s_cpuif_wr_biten);
            if (wr_req && s_cpuif_addr == ADDR_FW_ERROR_FATAL)
                fw_err_q <= wr_merge(fw_err_q, s_cpuif_wr_data, s_cpuif_wr_biten);
            if (wr_req && s_cpuif_addr == ADDR_SCRATCH_LOCK)  // Set-only bit
                scratch_lock <= scratch_lock | (s_cpuif_wr_data[0] & s_cpuif_wr_biten[0]);
            if (wr_req && s_cpuif_addr == ADDR_SCRATCH && !scratch_lock)
                scratch <= wr_merge(scratch, s_cpuif_wr_data, s_cpuif_wr_biten);
            if (wr_req && s_cpuif_addr == ADDR_GENERIC_OUT)
                generic_output_wires <= wr_merge(generic_output_wires, s_cpuif_wr_data,
                                                 s_cpuif_wr_biten);
        end
    end

    assign error_fatal = (|hw_err_q) | (|fw_err_q);

    //////////////////////////////////////////////////////////////////////
    // Timer write strobes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (s_cpuif_addr)
            ADDR_MTIME_H:    timer_cur = mtime[MTIME_W-1:DW];
            ADDR_MTIMECMP_L: timer_cur = mtimecmp[DW-1:0];
            ADDR_MTIMECMP_H: timer_cur = mtimecmp[MTIME_W-1:DW];
            default:         timer_cur = mtime[DW-1:0];
        endcase
    end

    assign mtime_l_we    = wr_req & (s_cpuif_addr == ADDR_MTIME_L);
    assign mtime_h_we    = wr_req & (s_cpuif_addr == ADDR_MTIME_H);
    assign mtimecmp_l_we = wr_req & (s_cpuif_addr == ADDR_MTIMECMP_L);
    assign mtimecmp_h_we = wr_req & (s_cpuif_addr == ADDR_MTIMECMP_H);
    assign mtime_wdata   = wr_merge(timer_cur, s_cpuif_wr_data, s_cpuif_wr_biten);

endmodule : mci_reg

// File: rtl/mci_reg_pkg.sv
/*
 * Management controller register package
 * Register map byte offsets, register and timer widths, and the
 * read-only identity values reported by the register file
 */

package mci_reg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Register file geometry
    //////////////////////////////////////////////////////////////////////

    localparam int MCI_REG_DATA_WIDTH     = 32;
    localparam int MCI_REG_MIN_ADDR_WIDTH = 6;     // Decoded byte address bits

    // Byte offsets
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_CAPABILITIES   = 6'h00;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_HW_REV_ID      = 6'h04;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_FLOW_STATUS    = 6'h08;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_HW_ERROR_FATAL = 6'h0C;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_FW_ERROR_FATAL = 6'h10;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_MTIME_L        = 6'h14;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_MTIME_H        = 6'h18;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_MTIMECMP_L     = 6'h1C;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_MTIMECMP_H     = 6'h20;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_SCRATCH_LOCK   = 6'h24;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_SCRATCH        = 6'h28;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_GENERIC_OUT    = 6'h2C;
    localparam logic [MCI_REG_MIN_ADDR_WIDTH-1:0] ADDR_GENERIC_IN     = 6'h30;

    //////////////////////////////////////////////////////////////////////
    // Identity values
    //////////////////////////////////////////////////////////////////////

    localparam logic [MCI_REG_DATA_WIDTH-1:0] CAPABILITIES_VAL = 32'h0000_0013;
    localparam logic [MCI_REG_DATA_WIDTH-1:0] HW_REV_ID_VAL    = 32'h0001_0002;

    // Hardware hook widths
    localparam int MTIME_W   = 64;                 // Two register halves
    localparam int HW_ERR_W  = 8;                  // Fatal error sources
    localparam int GENERIC_W = 32;                 // Generic in/out wires

endpackage : mci_reg_pkg

// File: rtl/mci_reg_top.sv
/*
 * Management register wrapper
 * Adapts the single-cycle fabric port to the register file: byte
 * strobes become bit enables, read and write errors merge into one
 * error line, and hold stays low since every access completes at once
 */

module mci_reg_top
    import cif_pkg::*;
    import mci_reg_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,

    // Fabric request/response
    input  logic                          cif_dv,
    input  logic                          cif_write,
    input  logic [CIF_ADDR_W-1:0]         cif_addr,
    input  logic [CIF_DATA_W-1:0]         cif_wdata,
    input  logic [CIF_STRB_W-1:0]         cif_wstrb,
    output logic [CIF_DATA_W-1:0]         cif_rdata,
    output logic                          cif_error,
    output logic                          cif_hold,

    // Hardware hooks
    input  logic [HW_ERR_W-1:0]           hw_error_fatal,
    input  logic [GENERIC_W-1:0]          generic_input_wires,
    output logic [GENERIC_W-1:0]          generic_output_wires,
    output logic                          error_fatal,

    // Timer
    input  logic [MTIME_W-1:0]            mtime,
    input  logic [MTIME_W-1:0]            mtimecmp,
    output logic                          mtime_l_we,
    output logic                          mtime_h_we,
    output logic                          mtimecmp_l_we,
    output logic                          mtimecmp_h_we,
    output logic [MCI_REG_DATA_WIDTH-1:0] mtime_wdata
);

    logic                          rd_err, wr_err;
    logic [MCI_REG_DATA_WIDTH-1:0] wr_biten;

    // Each strobe fans out to its byte lane
    for (genvar i = 0; i < CIF_STRB_W; i++) begin : g_strb_to_biten
        assign wr_biten[i*8 +: 8] = {8{cif_wstrb[i]}};
    end

    assign cif_error = rd_err | wr_err;
    assign cif_hold  = 1'b0;                       // Single-cycle access, no wait states

    mci_reg u_mci_reg (
        .clk                  (clk),
        .rst                  (rst),
        .s_cpuif_req          (cif_dv),
        .s_cpuif_req_is_wr    (cif_write),
        .s_cpuif_addr         (cif_addr[MCI_REG_MIN_ADDR_WIDTH-1:0]),  // Window only
        .s_cpuif_wr_data      (cif_wdata),
        .s_cpuif_wr_biten     (wr_biten),
        .s_cpuif_rd_data      (cif_rdata),
        .s_cpuif_rd_err       (rd_err),
        .s_cpuif_wr_err       (wr_err),
        .hw_error_fatal       (hw_error_fatal),
        .generic_input_wires  (generic_input_wires),
        .generic_output_wires (generic_output_wires),
        .error_fatal          (error_fatal),
        .mtime                (mtime),
        .mtimecmp             (mtimecmp),
        .mtime_l_we           (mtime_l_we),
        .mtime_h_we           (mtime_h_we),
        .mtimecmp_l_we        (mtimecmp_l_we),
        .mtimecmp_h_we        (mtimecmp_h_we),
        .mtime_wdata          (mtime_wdata)
    );

endmodule : mci_reg_top

// File: rtl/mci_subsys_top.sv
/*
 * Management controller subsystem top
 * Fabric-facing register wrapper plus the machine timer
 */

module mci_subsys_top
    import cif_pkg::*;
    import mci_reg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cif_dv,
    input  logic                  cif_write,
    input  logic [CIF_ADDR_W-1:0] cif_addr,
    input  logic [CIF_DATA_W-1:0] cif_wdata,
    input  logic [CIF_STRB_W-1:0] cif_wstrb,
    output logic [CIF_DATA_W-1:0] cif_rdata,
    output logic                  cif_error,
    output logic                  cif_hold,
    input  logic [HW_ERR_W-1:0]   hw_error_fatal,
    input  logic [GENERIC_W-1:0]  generic_input_wires,
    output logic [GENERIC_W-1:0]  generic_output_wires,
    output logic                  error_fatal,
    output logic                  timer_int
);

    // Timer strobes out, timer value back
    logic                          mtime_l_we, mtime_h_we;
    logic                          mtimecmp_l_we, mtimecmp_h_we;
    logic [MCI_REG_DATA_WIDTH-1:0] mtime_wdata;
    logic [MTIME_W-1:0]            mtime, mtimecmp;

    mci_reg_top u_mci_reg_top (
        .clk (clk), .rst (rst),
        .cif_dv (cif_dv), .cif_write (cif_write), .cif_addr (cif_addr),
        .cif_wdata (cif_wdata), .cif_wstrb (cif_wstrb), .cif_rdata (cif_rdata),
        .cif_error (cif_error), .cif_hold (cif_hold),
        .hw_error_fatal (hw_error_fatal), .generic_input_wires (generic_input_wires),
        .generic_output_wires (generic_output_wires), .error_fatal (error_fatal),
        .mtime (mtime), .mtimecmp (mtimecmp),
        .mtime_l_we (mtime_l_we), .mtime_h_we (mtime_h_we),
        .mtimecmp_l_we (mtimecmp_l_we), .mtimecmp_h_we (mtimecmp_h_we),
        .mtime_wdata (mtime_wdata)
    );

    mci_mtime u_mci_mtime (
        .clk (clk), .rst (rst),
        .mtime_l_we (mtime_l_we), .mtime_h_we (mtime_h_we),
        .mtimecmp_l_we (mtimecmp_l_we), .mtimecmp_h_we (mtimecmp_h_we),
        .mtime_wdata (mtime_wdata),
        .mtime (mtime), .mtimecmp (mtimecmp), .timer_int (timer_int)
    );

endmodule : mci_subsys_top
